// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////

	// Data and instruction word
	typedef logic [15:0] word_t;
	// Register index, sixteen registers
	typedef logic [3:0]  reg_addr_t;
	// Flags packed as {N, Z, V}
	typedef logic [2:0]  flags_t;

	// Flag bit positions
	localparam int FLAG_N = 2;
	localparam int FLAG_Z = 1;
	localparam int FLAG_V = 0;

	// JAL link register
	localparam reg_addr_t LINK_REG = 4'd15;

	// First fetch address
	localparam word_t RESET_PC = 16'h0000;

	// Data memory, word addressed by low bits
	localparam int DMEM_DEPTH = 64;
	localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	// Opcodes in bits 15:12, 4'h7 and 4'hA fall through as no-ops
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_ADDZ = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_NOR  = 4'h4,
		OP_SLL  = 4'h5,
		OP_SRL  = 4'h6,
		OP_LW   = 4'h8,
		OP_SW   = 4'h9,
		OP_LLB  = 4'hB,
		OP_B    = 4'hC,
		OP_JAL  = 4'hD,
		OP_JR   = 4'hE,
		OP_HLT  = 4'hF
	} opcode_t;

	// ALU functions
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_NOR,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS
	} alu_op_t;

	// Operand source into execute
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	// Branch condition, bits 11:9 of B
	typedef enum logic [2:0] {
		COND_EQ,
		COND_NE,
		COND_GT,
		COND_LT,
		COND_GE,
		COND_LE,
		COND_OV,
		COND_ALWAYS
	} cond_t;

endpackage

`default_nettype wire

// ==== rtl/cpu_ifs.sv ====
`default_nettype none
`timescale 1ns/1ps

// ID/EX register contents
interface ex_bus_if import cpu_pkg::*; ();
	logic      valid;
	alu_op_t   alu_op;
	opcode_t   opcode;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t     rs_data;
	word_t     rt_data;
	word_t     imm;
	cond_t     cond;
	reg_addr_t dst;
	logic      we;
	logic      mem_rd;
	logic      mem_wr;
	// Address of the following instruction
	word_t     pc_next;

	modport producer(output valid, alu_op, opcode, rs_addr, rt_addr, rs_data, rt_data,
		imm, cond, dst, we, mem_rd, mem_wr, pc_next);
	modport consumer(input valid, alu_op, opcode, rs_addr, rt_addr, rs_data, rt_data,
		imm, cond, dst, we, mem_rd, mem_wr, pc_next);
	// Forwarding and load-use view
	modport monitor(input valid, rs_addr, rt_addr, dst, mem_rd);
endinterface

// EX/MEM register contents
interface mem_bus_if import cpu_pkg::*; ();
	logic      valid;
	word_t     result;
	word_t     st_data;
	reg_addr_t dst;
	logic      we;
	logic      mem_rd;
	logic      mem_wr;
	logic      halt;

	modport producer(output valid, result, st_data, dst, we, mem_rd, mem_wr, halt);
	modport consumer(input valid, result, st_data, dst, we, mem_rd, mem_wr, halt);
	modport monitor(input valid, dst, we);
endinterface

// MEM/WB register contents, also the register file write port
interface wb_bus_if import cpu_pkg::*; ();
	logic      valid;
	reg_addr_t dst;
	word_t     data;
	logic      we;
	logic      halt;

	modport producer(output valid, dst, data, we, halt);
	modport consumer(input valid, dst, data, we, halt);
	modport monitor(input valid, dst, we);
endinterface

`default_nettype wire

// ==== rtl/instr_fetch.sv ====
`default_nettype none
`timescale 1ns/1ps

module instr_fetch import cpu_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  word_t instr,
	input  logic  stall,
	input  logic  redirect,
	input  word_t target,
	input  logic  hlt,
	output word_t pc,
	output word_t id_instr,
	output word_t id_pc,
	output logic  id_valid
);

	word_t pc_inc;
	logic  if_load;

	// Sequential successor, also handed down as the link value
	assign pc_inc = pc + 16'd1;

	// IF/ID takes a new word only when nothing holds or kills it
	assign if_load = !hlt && !redirect && !stall;

	// PC
	// Halt beats redirect, redirect beats stall
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_PC;
		end else if (!hlt) begin
			if (redirect) begin
				pc <= target;
			end else if (!stall) begin
				pc <= pc_inc;
			end
		end
	end

	// IF/ID valid
	// Redirect turns the word fetched this cycle into a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_valid <= 1'b0;
		end else if (!hlt) begin
			if (redirect) begin
				id_valid <= 1'b0;
			end else if (!stall) begin
				id_valid <= 1'b1;
			end
		end
	end

	// IF/ID payload
	always_ff @(posedge clk) begin
		if (if_load) begin
			id_instr <= instr;
			id_pc    <= pc_inc;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/instr_decode.sv ====
`default_nettype none
`timescale 1ns/1ps

module instr_decode import cpu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  word_t      id_instr,
	input  word_t      id_pc,
	input  logic       id_valid,
	input  logic       stall,
	input  logic       flush,
	wb_bus_if.consumer wb,
	ex_bus_if.producer ex,
	output reg_addr_t  rs_addr,
	output reg_addr_t  rt_addr,
	output logic       rs_used,
	output logic       rt_used
);

	opcode_t   op;
	alu_op_t   alu_op;
	reg_addr_t dst;
	word_t     imm;
	logic      we;
	logic      mem_rd;
	logic      mem_wr;
	logic      rs_use;
	logic      rt_use;
	word_t     regs [16];
	word_t     rs_val;
	word_t     rt_val;
	logic      rf_we;
	logic      halted;

	assign op = opcode_t'(id_instr[15:12]);
	assign halted = wb.valid && wb.halt;

	// Source fields
	// SW reads its store data from the destination field
	assign rs_addr = id_instr[7:4];
	assign rt_addr = (op == OP_SW) ? id_instr[11:8] : id_instr[3:0];

	assign rs_used = id_valid && rs_use;
	assign rt_used = id_valid && rt_use;

	////////////////////////////////////////
	// Control decode
	////////////////////////////////////////
	always_comb begin
		alu_op = ALU_ADD;
		dst    = id_instr[11:8];
		imm    = '0;
		we     = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		rs_use = 1'b0;
		rt_use = 1'b0;
		case (op)
			OP_ADD, OP_ADDZ, OP_SUB, OP_AND, OP_NOR: begin
				we     = 1'b1;
				rs_use = 1'b1;
				rt_use = 1'b1;
				if (op == OP_SUB) alu_op = ALU_SUB;
				if (op == OP_AND) alu_op = ALU_AND;
				if (op == OP_NOR) alu_op = ALU_NOR;
			end
			OP_SLL, OP_SRL: begin
				// 4-bit shift amount, unsigned
				alu_op = (op == OP_SLL) ? ALU_SLL : ALU_SRL;
				imm    = {12'h000, id_instr[3:0]};
				we     = 1'b1;
				rs_use = 1'b1;
			end
			OP_LW, OP_SW: begin
				// Base plus signed 4-bit offset
				imm    = {{12{id_instr[3]}}, id_instr[3:0]};
				we     = (op == OP_LW);
				mem_rd = (op == OP_LW);
				mem_wr = (op == OP_SW);
				rs_use = 1'b1;
				rt_use = (op == OP_SW);
			end
			OP_LLB: begin
				alu_op = ALU_PASS;
				imm    = {{8{id_instr[7]}}, id_instr[7:0]};
				we     = 1'b1;
			end
			// Offset relative to the next pc
			OP_B: imm = {{7{id_instr[8]}}, id_instr[8:0]};
			OP_JAL: begin
				imm = {{4{id_instr[11]}}, id_instr[11:0]};
				dst = LINK_REG;
				we  = 1'b1;
			end
			OP_JR: rs_use = 1'b1;
			// HLT and unused encodings carry no control bits
			default: ;
		endcase
	end

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////

	// r0 never stored
	assign rf_we = wb.valid && wb.we && (wb.dst != '0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (rf_we) begin
			regs[wb.dst] <= wb.data;
		end
	end

	// Reads see a write-back in the same cycle
	assign rs_val = (rs_addr == '0) ? '0 :
		(rf_we && wb.dst == rs_addr) ? wb.data : regs[rs_addr];
	assign rt_val = (rt_addr == '0) ? '0 :
		(rf_we && wb.dst == rt_addr) ? wb.data : regs[rt_addr];

	// ID/EX valid
	// Stall and flush both insert a bubble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex.valid <= 1'b0;
		end else if (!halted) begin
			ex.valid <= id_valid && !stall && !flush;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		if (!halted) begin
			ex.alu_op  <= alu_op;
			ex.opcode  <= op;
			ex.rs_addr <= rs_addr;
			ex.rt_addr <= rt_addr;
			ex.rs_data <= rs_val;
			ex.rt_data <= rt_val;
			ex.imm     <= imm;
			ex.cond    <= cond_t'(id_instr[11:9]);
			ex.dst     <= dst;
			// Writes to r0 are dropped here so they never retire
			ex.we      <= we && (dst != '0);
			ex.mem_rd  <= mem_rd;
			ex.mem_wr  <= mem_wr;
			ex.pc_next <= id_pc;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/execute.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute import cpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	ex_bus_if.consumer  ex,
	mem_bus_if.producer mem,
	wb_bus_if.consumer  wb,
	input  fwd_sel_t    fwd_a,
	input  fwd_sel_t    fwd_b,
	input  logic        hlt,
	output logic        redirect,
	output word_t       target
);

	word_t  op_a;
	word_t  op_b;
	word_t  alu_b;
	word_t  alu_y;
	word_t  result;
	flags_t flags;
	flags_t flags_nxt;
	logic   ovf;
	logic   use_imm;
	logic   cond_met;
	logic   taken;
	logic   we_eff;

	// Forwarding mux, one per operand
	function automatic word_t fwd_pick(fwd_sel_t sel, word_t rf_val, word_t mem_val,
		word_t wb_val);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return rf_val;
		endcase
	endfunction

	assign op_a = fwd_pick(fwd_a, ex.rs_data, mem.result, wb.data);
	assign op_b = fwd_pick(fwd_b, ex.rt_data, mem.result, wb.data);

	// Shifts, memory address and LLB take the immediate
	assign use_imm = ex.opcode inside {OP_SLL, OP_SRL, OP_LW, OP_SW, OP_LLB};
	assign alu_b   = use_imm ? ex.imm : op_b;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////
	always_comb begin
		ovf = 1'b0;
		case (ex.alu_op)
			ALU_ADD: begin
				alu_y = op_a + alu_b;
				ovf   = (op_a[15] == alu_b[15]) && (alu_y[15] != op_a[15]);
			end
			ALU_SUB: begin
				alu_y = op_a - alu_b;
				ovf   = (op_a[15] != alu_b[15]) && (alu_y[15] != op_a[15]);
			end
			ALU_AND: alu_y = op_a & alu_b;
			ALU_NOR: alu_y = ~(op_a | alu_b);
			ALU_SLL: alu_y = op_a << alu_b[3:0];
			ALU_SRL: alu_y = op_a >> alu_b[3:0];
			default: alu_y = alu_b;
		endcase
	end

	// Arithmetic sets N Z V, logic sets Z alone
	always_comb begin
		flags_nxt = flags;
		case (ex.opcode)
			OP_ADD, OP_ADDZ, OP_SUB: flags_nxt = {alu_y[15], alu_y == '0, ovf};
			OP_AND, OP_NOR: flags_nxt[FLAG_Z] = (alu_y == '0);
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (ex.valid && !hlt) begin
			flags <= flags_nxt;
		end
	end

	////////////////////////////////////////
	// Branch resolution
	////////////////////////////////////////
	always_comb begin
		case (ex.cond)
			COND_EQ: cond_met = flags[FLAG_Z];
			COND_NE: cond_met = !flags[FLAG_Z];
			COND_GT: cond_met = !flags[FLAG_Z] && !flags[FLAG_N];
			COND_LT: cond_met = flags[FLAG_N];
			COND_GE: cond_met = flags[FLAG_Z] || !flags[FLAG_N];
			COND_LE: cond_met = flags[FLAG_N] || flags[FLAG_Z];
			COND_OV: cond_met = flags[FLAG_V];
			default: cond_met = 1'b1;
		endcase
	end

	assign taken = ex.valid && ((ex.opcode == OP_B && cond_met) ||
		ex.opcode == OP_JAL || ex.opcode == OP_JR);
	assign redirect = taken && !hlt;
	// JR through the forwarded register, the rest pc relative
	assign target = (ex.opcode == OP_JR) ? op_a : ex.pc_next + ex.imm;

	// ADDZ writes only when Z was already set
	assign we_eff = ex.we && !(ex.opcode == OP_ADDZ && !flags[FLAG_Z]);
	// JAL returns the link address
	assign result = (ex.opcode == OP_JAL) ? ex.pc_next : alu_y;

	// EX/MEM control
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem.valid <= 1'b0;
			mem.halt  <= 1'b0;
		end else if (!hlt) begin
			mem.valid <= ex.valid;
			mem.halt  <= ex.valid && (ex.opcode == OP_HLT);
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		if (!hlt) begin
			mem.result  <= result;
			mem.st_data <= op_b;
			mem.dst     <= ex.dst;
			mem.we      <= we_eff;
			mem.mem_rd  <= ex.mem_rd;
			mem.mem_wr  <= ex.mem_wr;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_stage import cpu_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	mem_bus_if.consumer mem,
	wb_bus_if.producer  wb,
	input  logic        hlt
);

	word_t              dmem [DMEM_DEPTH];
	logic [DMEM_AW-1:0] addr;
	word_t              ld_data;
	logic               st_en;

	// Word address wraps onto the small array
	assign addr    = mem.result[DMEM_AW-1:0];
	assign ld_data = dmem[addr];
	// No stores once the pipeline has halted
	assign st_en   = mem.valid && mem.mem_wr && !hlt;

	// Data memory
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (st_en) begin
			dmem[addr] <= mem.st_data;
		end
	end

	// MEM/WB control
	// Holds the halting entry forever
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb.valid <= 1'b0;
			wb.halt  <= 1'b0;
		end else if (!hlt) begin
			wb.valid <= mem.valid;
			wb.halt  <= mem.valid && mem.halt;
		end
	end

	// MEM/WB payload, load data or ALU result
	always_ff @(posedge clk) begin
		if (!hlt) begin
			wb.dst  <= mem.dst;
			wb.data <= mem.mem_rd ? ld_data : mem.result;
			wb.we   <= mem.we;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
	ex_bus_if.monitor  ex,
	mem_bus_if.monitor mem,
	wb_bus_if.monitor  wb,
	input  reg_addr_t  rs_addr,
	input  reg_addr_t  rt_addr,
	input  logic       rs_used,
	input  logic       rt_used,
	output fwd_sel_t   fwd_a,
	output fwd_sel_t   fwd_b,
	output logic       stall
);

	logic mem_wr_ok;
	logic wb_wr_ok;
	logic load_in_ex;

	// Live register writes further down the pipe, r0 excluded
	assign mem_wr_ok = mem.valid && mem.we && (mem.dst != '0);
	assign wb_wr_ok  = wb.valid && wb.we && (wb.dst != '0);

	// Youngest producer wins
	function automatic fwd_sel_t src_sel(reg_addr_t src, logic m_ok, reg_addr_t m_dst,
		logic w_ok, reg_addr_t w_dst);
		if (m_ok && m_dst == src) return FWD_MEM;
		if (w_ok && w_dst == src) return FWD_WB;
		return FWD_REG;
	endfunction

	assign fwd_a = src_sel(ex.rs_addr, mem_wr_ok, mem.dst, wb_wr_ok, wb.dst);
	assign fwd_b = src_sel(ex.rt_addr, mem_wr_ok, mem.dst, wb_wr_ok, wb.dst);

	////////////////////////////////////////
	// Load-use
	////////////////////////////////////////

	// Load data exists only after the memory stage
	assign load_in_ex = ex.valid && ex.mem_rd && (ex.dst != '0);

	// One cycle hold, the value then comes from write-back
	assign stall = load_in_ex &&
		((rs_used && rs_addr == ex.dst) || (rt_used && rt_addr == ex.dst));

endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	output word_t     pc,
	input  word_t     instr,
	output logic      hlt,
	output logic      wb_valid,
	output reg_addr_t wb_addr,
	output word_t     wb_data
);

	ex_bus_if  ex_bus();
	mem_bus_if mem_bus();
	wb_bus_if  wb_bus();

	word_t     id_instr;
	word_t     id_pc;
	logic      id_valid;
	logic      stall;
	logic      redirect;
	word_t     target;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	logic      rs_used;
	logic      rt_used;
	fwd_sel_t  fwd_a;
	fwd_sel_t  fwd_b;

	// Halt is seen once HLT sits in write-back
	assign hlt = wb_bus.valid && wb_bus.halt;

	// Retirement trace, the register file write port
	assign wb_valid = wb_bus.valid && wb_bus.we;
	assign wb_addr  = wb_bus.dst;
	assign wb_data  = wb_bus.data;

	////////////////////////////////////////
	// Stages
	////////////////////////////////////////
	instr_fetch u_fetch (
		.clk      (clk),
		.arst_n   (arst_n),
		.instr    (instr),
		.stall    (stall),
		.redirect (redirect),
		.target   (target),
		.hlt      (hlt),
		.pc       (pc),
		.id_instr (id_instr),
		.id_pc    (id_pc),
		.id_valid (id_valid)
	);

	// Taken transfer also kills the instruction in decode
	instr_decode u_decode (
		.clk      (clk),
		.arst_n   (arst_n),
		.id_instr (id_instr),
		.id_pc    (id_pc),
		.id_valid (id_valid),
		.stall    (stall),
		.flush    (redirect),
		.wb       (wb_bus.consumer),
		.ex       (ex_bus.producer),
		.rs_addr  (rs_addr),
		.rt_addr  (rt_addr),
		.rs_used  (rs_used),
		.rt_used  (rt_used)
	);

	execute u_execute (
		.clk      (clk),
		.arst_n   (arst_n),
		.ex       (ex_bus.consumer),
		.mem      (mem_bus.producer),
		.wb       (wb_bus.consumer),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b),
		.hlt      (hlt),
		.redirect (redirect),
		.target   (target)
	);

	mem_stage u_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.mem    (mem_bus.consumer),
		.wb     (wb_bus.producer),
		.hlt    (hlt)
	);

	// Forwarding selects and load-use stall
	hazard_unit u_hazard (
		.ex      (ex_bus.monitor),
		.mem     (mem_bus.monitor),
		.wb      (wb_bus.monitor),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_used (rs_used),
		.rt_used (rt_used),
		.fwd_a   (fwd_a),
		.fwd_b   (fwd_b),
		.stall   (stall)
	);

endmodule

`default_nettype wire

// ==== tests/cpu_assert.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_assert import cpu_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  logic  stall,
	input  logic  redirect,
	input  logic  hlt,
	input  word_t pc,
	input  logic  mem_valid,
	input  logic  mem_wr,
	input  logic  wb_valid
);

	// Cycles since reset release, saturates at four
	logic [2:0] since_reset;
	// Taken transfers one and two cycles back
	logic [1:0] redirect_hist;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			since_reset <= 3'd0;
		end else if (since_reset != 3'd4) begin
			since_reset <= since_reset + 3'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			redirect_hist <= 2'b00;
		end else begin
			redirect_hist <= {redirect_hist[0], redirect};
		end
	end

	// Load-use and a taken transfer never meet in execute
	assert property (@(posedge clk) disable iff (!arst_n) !(redirect && stall))
		else $error("redirect raised during a load-use stall");

	// Frozen fetch
	assert property (@(posedge clk) disable iff (!arst_n) hlt |=> $stable(pc))
		else $error("pc moved while halted");

	// The flushed pair behind a taken transfer never stores
	assert property (@(posedge clk) disable iff (!arst_n)
		(redirect_hist[0] || redirect_hist[1]) |=> !(mem_valid && mem_wr))
		else $error("store behind a taken transfer reached the memory stage");

	// Nothing can retire before the pipe has filled
	assert property (@(posedge clk) disable iff (!arst_n) (since_reset < 3'd4) |-> !wb_valid)
		else $error("write-back before the pipeline filled");

endmodule

bind cpu cpu_assert u_assert (
	.clk       (clk),
	.arst_n    (arst_n),
	.stall     (stall),
	.redirect  (redirect),
	.hlt       (hlt),
	.pc        (pc),
	.mem_valid (mem_bus.valid),
	.mem_wr    (mem_bus.mem_wr),
	.wb_valid  (wb_valid)
);

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

	logic      clk;
	logic      arst_n;
	word_t     pc;
	word_t     instr;
	logic      hlt;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;

	// Instruction memory, indexed by the low pc byte
	word_t     imem [256];
	// Expected register writes in program order
	reg_addr_t exp_addr [$];
	word_t     exp_data [$];
	word_t     ref_regs [16];
	logic      ref_halted;

	int   p;
	int   got_count;
	int   test_errors;
	int   total_errors;
	int   tests_run;
	int   tests_failed;
	logic checking;
	// Set once a test times out, later tests are skipped
	logic aborted;

	assign instr = imem[pc[7:0]];

	cpu u_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.pc       (pc),
		.instr    (instr),
		.hlt      (hlt),
		.wb_valid (wb_valid),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////
	function automatic word_t rtype(opcode_t op, reg_addr_t d, reg_addr_t s, reg_addr_t t);
		return {op, d, s, t};
	endfunction

	function automatic word_t llb(reg_addr_t d, logic [7:0] imm);
		return {OP_LLB, d, imm};
	endfunction

	function automatic word_t branch(cond_t c, logic [8:0] off);
		return {OP_B, c, off};
	endfunction

	function automatic word_t jal_to(logic [11:0] off);
		return {OP_JAL, off};
	endfunction

	function automatic word_t jr_via(reg_addr_t s);
		return {OP_JR, 4'h0, s, 4'h0};
	endfunction

	function automatic word_t memop(opcode_t op, reg_addr_t d, reg_addr_t b, logic [3:0] off);
		return {op, d, b, off};
	endfunction

	function automatic word_t halt_word();
		return {OP_HLT, 12'h000};
	endfunction

	// Unwritten words halt, low bits carry the address
	task automatic clear_prog();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {4'hF, 4'h0, i[7:0]};
		end
		p = 0;
	endtask

	task automatic put(word_t w);
		imem[p[7:0]] = w;
		p++;
	endtask

	////////////////////////////////////////
	// ISA reference
	////////////////////////////////////////
	function automatic void ref_write(reg_addr_t d, word_t v);
		// r0 writes vanish
		if (d != 4'd0) begin
			ref_regs[d] = v;
			exp_addr.push_back(d);
			exp_data.push_back(v);
		end
	endfunction

	// Runs the loaded program one instruction at a time
	function automatic void ref_run();
		word_t     pc_r;
		word_t     w;
		word_t     a;
		word_t     b;
		word_t     y;
		word_t     npc;
		word_t     addr;
		word_t     dm [64];
		flags_t    f;
		opcode_t   op;
		reg_addr_t d;
		int        sa;
		int        sb;
		int        sum;
		logic      v;
		logic      z_old;
		logic      met;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 16; i++) begin
			ref_regs[i] = 16'h0000;
		end
		for (int i = 0; i < 64; i++) begin
			dm[i] = 16'h0000;
		end
		f = 3'b000;
		pc_r = 16'h0000;
		ref_halted = 1'b0;
		for (int steps = 0; steps < 4000 && !ref_halted; steps++) begin
			w = imem[pc_r[7:0]];
			op = opcode_t'(w[15:12]);
			d = w[11:8];
			a = ref_regs[w[7:4]];
			b = ref_regs[w[3:0]];
			sa = int'($signed(a));
			sb = int'($signed(b));
			npc = pc_r + 16'd1;
			addr = a + {{12{w[3]}}, w[3:0]};
			case (op)
				OP_ADD, OP_ADDZ, OP_SUB: begin
					y = (op == OP_SUB) ? a - b : a + b;
					sum = (op == OP_SUB) ? sa - sb : sa + sb;
					v = (sum > 32767) || (sum < -32768);
					z_old = f[FLAG_Z];
					f = {y[15], y == 16'h0000, v};
					if (op != OP_ADDZ || z_old) ref_write(d, y);
				end
				OP_AND, OP_NOR: begin
					y = (op == OP_AND) ? (a & b) : ~(a | b);
					f[FLAG_Z] = (y == 16'h0000);
					ref_write(d, y);
				end
				OP_SLL: ref_write(d, a << w[3:0]);
				OP_SRL: ref_write(d, a >> w[3:0]);
				OP_LW:  ref_write(d, dm[addr[5:0]]);
				OP_SW:  dm[addr[5:0]] = ref_regs[d];
				OP_LLB: ref_write(d, {{8{w[7]}}, w[7:0]});
				OP_B: begin
					case (w[11:9])
						3'd0: met = f[FLAG_Z];
						3'd1: met = !f[FLAG_Z];
						3'd2: met = !f[FLAG_Z] && !f[FLAG_N];
						3'd3: met = f[FLAG_N];
						3'd4: met = f[FLAG_Z] || !f[FLAG_N];
						3'd5: met = f[FLAG_N] || f[FLAG_Z];
						3'd6: met = f[FLAG_V];
						default: met = 1'b1;
					endcase
					if (met) npc = npc + {{7{w[8]}}, w[8:0]};
				end
				OP_JAL: begin
					// Link is the sequential successor
					ref_write(4'd15, npc);
					npc = npc + {{4{w[11]}}, w[11:0]};
				end
				OP_JR:  npc = a;
				OP_HLT: ref_halted = 1'b1;
				default: ;
			endcase
			pc_r = npc;
		end
	endfunction

	////////////////////////////////////////
	// Compare
	////////////////////////////////////////
	task automatic check_addr(reg_addr_t got, reg_addr_t exp, int idx);
		if (got !== exp) begin
			$display("FAIL %0t: write %0d went to r%0d, expected r%0d", $time, idx, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_word(word_t got, word_t exp, int idx);
		if (got !== exp) begin
			$display("FAIL %0t: write %0d data %h, expected %h", $time, idx, got, exp);
			test_errors++;
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (checking && wb_valid) begin
			if (got_count < exp_addr.size()) begin
				check_addr(wb_addr, exp_addr[got_count], got_count);
				check_word(wb_data, exp_data[got_count], got_count);
			end else begin
				$display("Extra write to r%0d at %0t, not on the reference path",
					wb_addr, $time);
				test_errors++;
			end
			got_count++;
		end
	end

	task automatic run_test(string name);
		int cycles;
		if (aborted) return;
		test_errors = 0;
		got_count = 0;
		ref_run();
		if (!ref_halted) begin
			$display("Reference for %s never reached a halt", name);
			test_errors++;
		end
		arst_n = 1'b0;
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;
		checking = 1'b1;
		cycles = 0;
		while (!hlt && cycles < 3000) begin
			@(posedge clk);
			#1 cycles++;
		end
		if (!hlt) begin
			$display("Timeout: %s never raised hlt", name);
			checking = 1'b0;
			aborted = 1'b1;
			test_errors++;
		end else begin
			// Halted pipe stays quiet
			repeat (10) begin
				@(negedge clk);
				if (!hlt) begin
					$display("hlt dropped after the halt in %s", name);
					test_errors++;
				end
			end
			@(posedge clk);
			#1 checking = 1'b0;
			if (got_count != exp_addr.size()) begin
				$display("%s retired %0d writes, reference has %0d", name, got_count,
					exp_addr.size());
				test_errors++;
			end
		end
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0) tests_failed++;
		$display("test %0d %s: %0d writes, %0d errors", tests_run, name, got_count,
			test_errors);
	endtask

	function automatic word_t random_instr();
		reg_addr_t d;
		reg_addr_t s;
		reg_addr_t t;
		d = {1'b0, 3'($urandom)};
		s = {1'b0, 3'($urandom)};
		t = {1'b0, 3'($urandom)};
		case ($urandom % 13)
			0:  return rtype(OP_ADD, d, s, t);
			1:  return rtype(OP_ADDZ, d, s, t);
			2:  return rtype(OP_SUB, d, s, t);
			3:  return rtype(OP_AND, d, s, t);
			4:  return rtype(OP_NOR, d, s, t);
			5:  return rtype(OP_SLL, d, s, 4'($urandom));
			6:  return rtype(OP_SRL, d, s, 4'($urandom));
			7:  return memop(OP_LW, d, s, 4'($urandom));
			8:  return memop(OP_SW, d, s, 4'($urandom));
			9:  return llb(d, 8'($urandom));
			// Forward only, so every program ends
			10: return branch(cond_t'(3'($urandom)), 9'($urandom % 4));
			11: return jal_to(12'($urandom % 3));
			default: return {4'hA, d, s, t};
		endcase
	endfunction

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////
	initial begin
		int tgt;
		int len;
		void'($urandom(41));
		arst_n = 1'b0;
		checking = 1'b0;
		aborted = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		total_errors = 0;
		clear_prog();

		// Dependent ALU chain
		put(llb(4'd1, 8'h35));
		put(llb(4'd2, 8'hFD));
		put(rtype(OP_ADD, 4'd3, 4'd1, 4'd2));
		put(rtype(OP_SUB, 4'd4, 4'd3, 4'd1));
		put(rtype(OP_SLL, 4'd5, 4'd4, 4'd3));
		put(rtype(OP_SRL, 4'd6, 4'd5, 4'd2));
		put(rtype(OP_NOR, 4'd7, 4'd6, 4'd3));
		put(rtype(OP_AND, 4'd8, 4'd7, 4'd1));
		put(rtype(OP_ADD, 4'd9, 4'd8, 4'd8));
		put(rtype(OP_ADD, 4'd10, 4'd1, 4'd6));
		put(rtype(OP_ADD, 4'd0, 4'd9, 4'd9));
		put(halt_word());
		run_test("alu_forwarding");

		// Loads, stores, load-use
		clear_prog();
		put(llb(4'd1, 8'h05));
		put(llb(4'd2, 8'h12));
		put(memop(OP_SW, 4'd2, 4'd1, 4'h0));
		put(llb(4'd3, 8'hF9));
		put(memop(OP_SW, 4'd3, 4'd1, 4'h3));
		put(memop(OP_LW, 4'd4, 4'd1, 4'h0));
		put(rtype(OP_ADD, 4'd5, 4'd4, 4'd4));
		put(memop(OP_LW, 4'd6, 4'd1, 4'h3));
		put(memop(OP_SW, 4'd6, 4'd1, 4'hF));
		put(memop(OP_LW, 4'd7, 4'd1, 4'hF));
		put(rtype(OP_SUB, 4'd8, 4'd7, 4'd6));
		put(halt_word());
		run_test("load_store");

		// Every condition under four flag states, then JAL and JR
		clear_prog();
		put(llb(4'd1, 8'h01));
		put(llb(4'd2, 8'h02));
		put(llb(4'd4, 8'h7F));
		put(rtype(OP_SLL, 4'd4, 4'd4, 4'd8));
		for (int st = 0; st < 4; st++) begin
			case (st)
				0: put(rtype(OP_SUB, 4'd3, 4'd1, 4'd2));
				1: put(rtype(OP_SUB, 4'd3, 4'd1, 4'd1));
				2: put(rtype(OP_SUB, 4'd3, 4'd2, 4'd1));
				default: put(rtype(OP_ADD, 4'd5, 4'd4, 4'd4));
			endcase
			for (int c = 0; c < 8; c++) begin
				put(branch(cond_t'(c[2:0]), 9'd1));
				put(llb(4'd11, 8'(st * 8 + c)));
			end
		end
		put(jal_to(12'd2));
		put(llb(4'd12, 8'hEE));
		put(llb(4'd12, 8'hEF));
		put(rtype(OP_ADD, 4'd13, 4'd15, 4'd0));
		tgt = p + 4;
		put(llb(4'd14, 8'(tgt)));
		put(jr_via(4'd14));
		put(llb(4'd6, 8'hBB));
		put(llb(4'd6, 8'hCC));
		put(llb(4'd7, 8'h5A));
		put(halt_word());
		run_test("branches_jumps");

		// ADDZ, and logic ops touching Z alone
		clear_prog();
		put(llb(4'd2, 8'h05));
		put(rtype(OP_SUB, 4'd3, 4'd2, 4'd2));
		put(rtype(OP_ADDZ, 4'd4, 4'd2, 4'd2));
		put(rtype(OP_ADDZ, 4'd5, 4'd2, 4'd2));
		put(rtype(OP_AND, 4'd6, 4'd1, 4'd2));
		put(rtype(OP_ADDZ, 4'd7, 4'd2, 4'd1));
		put(rtype(OP_SUB, 4'd3, 4'd1, 4'd2));
		// Zero result with N set before it
		put(rtype(OP_NOR, 4'd8, 4'd3, 4'd2));
		put(branch(COND_LT, 9'd1));
		put(llb(4'd9, 8'h01));
		put(rtype(OP_AND, 4'd10, 4'd2, 4'd2));
		put(branch(COND_EQ, 9'd1));
		put(llb(4'd9, 8'h02));
		put(halt_word());
		run_test("addz_flags");

		// Halt behind a taken branch is skipped
		clear_prog();
		put(llb(4'd1, 8'h01));
		put(branch(COND_ALWAYS, 9'd1));
		put(halt_word());
		put(llb(4'd2, 8'h02));
		put(halt_word());
		put(llb(4'd3, 8'h03));
		put(llb(4'd4, 8'h04));
		run_test("halt");

		// Random programs
		for (int n = 0; n < 12; n++) begin
			clear_prog();
			for (int r = 1; r < 8; r++) begin
				put(llb(4'(r), 8'($urandom)));
			end
			len = 30 + int'($urandom % 20);
			for (int k = 0; k < len; k++) begin
				put(random_instr());
			end
			put(halt_word());
			run_test($sformatf("random_%0d", n));
		end

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
		if (total_errors == 0 && tests_failed == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/cpu_pkg.sv
rtl/cpu_ifs.sv
rtl/instr_fetch.sv
rtl/instr_decode.sv
rtl/execute.sv
rtl/mem_stage.sv
rtl/hazard_unit.sv
rtl/cpu.sv
tests/cpu_assert.sv
tests/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := cpu_tb
FILELIST  := files.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir
